// ==== dv/apb_xbar_vectors.txt ====
# name master conc write addr wdata exp_rdata exp_slverr, data in hex, conc 1 pairs with next line
# region <slave> <enable> changes a decode window before the following transfers
wr_m0_s0     0 0 1 00000010 11223344 00000000 0
rd_m0_s0     0 0 0 00000010 00000000 11223344 0
wr_m0_s1     0 0 1 00001020 a5a5a5a5 00000000 0
rd_m0_s1     0 0 0 00001020 00000000 a5a5a5a5 0
wr_m1_s0     1 0 1 00000030 cafef00d 00000000 0
rd_m1_s0     1 0 0 00000030 00000000 cafef00d 0
wr_m1_s1     1 0 1 00001040 0badbeef 00000000 0
rd_m1_s1     1 0 0 00001040 00000000 0badbeef 0
rd_fill_s0   0 0 0 00000100 00000000 fffffeff 0
miss_m0      0 0 0 00002000 00000000 00000000 1
miss_m1      1 0 1 80000000 12345678 00000000 1
region 1 0
dis_rd_m0_s1 0 0 0 00001020 00000000 00000000 1
dis_wr_m1_s1 1 0 1 00001040 deadc0de 00000000 1
region 1 1
reen_rd_m1   1 0 0 00001040 00000000 0badbeef 0
same_wr_m0   0 1 1 00000200 01010101 00000000 0
same_wr_m1   1 0 1 00000204 02020202 00000000 0
same_rd_m0   0 1 0 00000204 00000000 02020202 0
same_rd_m1   1 0 0 00000200 00000000 01010101 0
diff_wr_m0   0 1 1 00000300 33333333 00000000 0
diff_wr_m1   1 0 1 00001300 44444444 00000000 0
diff_rd_m0   0 1 0 00001300 00000000 44444444 0
diff_rd_m1   1 0 0 00000300 00000000 33333333 0
err_rd_m0    0 1 0 000000ee 00000000 00000000 1
ok_rd_m1     1 0 0 00001020 00000000 a5a5a5a5 0
err_wr_m1    1 1 1 000010ee 55555555 00000000 1
ok_rd_m0     0 0 0 00000010 00000000 11223344 0

// ==== apb_xbar.f ====
hw/apb_xbar_pkg.sv
hw/apb_master_port.sv
hw/apb_xbar_switch.sv
hw/apb_slave_port.sv
hw/apb_xbar.sv
dv/apb_xbar_clkgen.sv
dv/apb_xbar_slave_model.sv
dv/apb_xbar_checker.sv
dv/apb_xbar_tb.sv

// ==== Bender.yml ====
package:
  name: apb_xbar

sources:
  - files:
      - hw/apb_xbar_pkg.sv
      - hw/apb_master_port.sv
      - hw/apb_xbar_switch.sv
      - hw/apb_slave_port.sv
      - hw/apb_xbar.sv
  - target: test
    files:
      - dv/apb_xbar_clkgen.sv
      - dv/apb_xbar_slave_model.sv
      - dv/apb_xbar_checker.sv
      - dv/apb_xbar_tb.sv

// ==== dv/apb_xbar_tb.sv ====
`timescale 1ns/1ns

module apb_xbar_tb;

    localparam int n_masters    = 2;
    localparam int n_slaves     = 2;
    localparam int xfer_timeout = 64;  // cycles per transfer
    localparam int rst_timeout  = 32;

    logic aclk;
    logic aresetn;
    apb_xbar_pkg::addr_region_t [n_slaves-1:0] regions;
    int   xfer_seq = 0;  // transfers started so far

    logic [n_masters-1:0]       m_psel;
    logic [n_masters-1:0]       m_penable;
    logic [n_masters-1:0]       m_pwrite;
    logic [n_masters-1:0][2:0]  m_pprot;
    logic [n_masters-1:0][31:0] m_paddr;
    logic [n_masters-1:0][31:0] m_pwdata;
    logic [n_masters-1:0][3:0]  m_pstrb;
    logic [n_masters-1:0]       m_pready;
    logic [n_masters-1:0][31:0] m_prdata;
    logic [n_masters-1:0]       m_pslverr;

    logic [n_slaves-1:0]        s_psel;
    logic [n_slaves-1:0]        s_penable;
    logic [n_slaves-1:0]        s_pwrite;
    logic [n_slaves-1:0][2:0]   s_pprot;
    logic [n_slaves-1:0][31:0]  s_paddr;
    logic [n_slaves-1:0][31:0]  s_pwdata;
    logic [n_slaves-1:0][3:0]   s_pstrb;
    logic [n_slaves-1:0]        s_pready;
    logic [n_slaves-1:0][31:0]  s_prdata;
    logic [n_slaves-1:0]        s_pslverr;

    apb_xbar_clkgen #(.period_ns(8), .reset_cycles(2)) u_clkgen (
        .o_aclk    (aclk),
        .o_aresetn (aresetn)
    );

    apb_xbar #(.n_masters(n_masters), .n_slaves(n_slaves)) i_apb_xbar (
        .aclk        (aclk),        .aresetn     (aresetn),     .i_regions   (regions),
        .i_m_psel    (m_psel),      .i_m_penable (m_penable),   .i_m_pwrite  (m_pwrite),
        .i_m_pprot   (m_pprot),     .i_m_paddr   (m_paddr),     .i_m_pwdata  (m_pwdata),
        .i_m_pstrb   (m_pstrb),     .o_m_pready  (m_pready),    .o_m_prdata  (m_prdata),
        .o_m_pslverr (m_pslverr),   .o_s_psel    (s_psel),      .o_s_penable (s_penable),
        .o_s_pwrite  (s_pwrite),    .o_s_pprot   (s_pprot),     .o_s_paddr   (s_paddr),
        .o_s_pwdata  (s_pwdata),    .o_s_pstrb   (s_pstrb),     .i_s_pready  (s_pready),
        .i_s_prdata  (s_prdata),    .i_s_pslverr (s_pslverr)
    );

    for (genvar s = 0; s < n_slaves; s++) begin : g_slv
        apb_xbar_slave_model #(.base_addr(32'(s) * 32'h1000), .seed(16'd7156)) u_slv_model (
            .aclk      (aclk),         .aresetn   (aresetn),
            .i_psel    (s_psel[s]),    .i_penable (s_penable[s]),
            .i_pwrite  (s_pwrite[s]),  .i_paddr   (s_paddr[s]),
            .i_pwdata  (s_pwdata[s]),  .o_pready  (s_pready[s]),
            .o_prdata  (s_prdata[s]),  .o_pslverr (s_pslverr[s])
        );
    end

    apb_xbar_checker #(.n_masters(n_masters), .n_slaves(n_slaves)) u_checker (
        .aclk        (aclk),        .aresetn   (aresetn),
        .i_pready    (m_pready),    .i_prdata  (m_prdata),  .i_pslverr (m_pslverr),
        .i_s_psel    (s_psel),      .i_s_penable (s_penable),
        .i_s_paddr   (s_paddr),     .i_s_pprot (s_pprot),   .i_s_pstrb (s_pstrb)
    );

    // true when no enabled window covers addr, limits inclusive
    function automatic logic decode_miss(input logic [31:0] addr);
        logic hit;
        hit = 1'b0;
        for (int s = 0; s < n_slaves; s++) begin
            if (regions[s].enable && addr >= regions[s].base && addr <= regions[s].limit) begin
                hit = 1'b1;
            end
        end
        return !hit;
    endfunction

    task automatic run_xfer(input int m, input string name, input logic wr,
                            input logic [31:0] addr, input logic [31:0] wdata,
                            input logic [31:0] exp_rdata, input logic exp_err);
        int         cycles;
        logic       got;
        logic [2:0] prot;
        logic [3:0] strb;
        cycles = 0;
        got    = 1'b0;
        xfer_seq++;
        prot   = xfer_seq[2:0];  // changes per transfer
        strb   = xfer_seq[3:0] ^ 4'b1010;
        @(negedge aclk);
        u_checker.expect_xfer(m, name, exp_rdata, exp_err, decode_miss(addr),
                              addr, prot, strb);
        m_psel[m]   = 1'b1;  // setup phase
        m_pwrite[m] = wr;
        m_paddr[m]  = addr;
        m_pwdata[m] = wdata;
        m_pprot[m]  = prot;
        m_pstrb[m]  = strb;
        @(negedge aclk);
        m_penable[m] = 1'b1;
        while (!got && cycles < xfer_timeout) begin
            @(posedge aclk);
            if (m_pready[m]) got = 1'b1;
            else cycles++;
        end
        @(negedge aclk);
        m_psel[m]    = 1'b0;
        m_penable[m] = 1'b0;
        if (!got) u_checker.note_timeout(m, name);
    endtask

    ////////////////////////////////////////////////////////////
    // vector player

    initial begin
        int          fd;
        int          n;
        int          cycles;
        int          m;
        int          conc;
        int          wr;
        int          eerr;
        int          idx;
        int          en;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [31:0] erd;
        string       line;
        string       tok;
        string       name;
        logic        pend;
        string       p_name;
        int          p_m;
        int          p_wr;
        int          p_err;
        logic [31:0] p_addr;
        logic [31:0] p_wdata;
        logic [31:0] p_erd;

        m_psel    = '0;
        m_penable = '0;
        m_pwrite  = '0;
        m_pprot   = '0;
        m_paddr   = '0;
        m_pwdata  = '0;
        m_pstrb   = '1;
        for (int s = 0; s < n_slaves; s++) begin
            regions[s].enable = 1'b1;
            regions[s].base   = 32'(s) * 32'h1000;
            regions[s].limit  = 32'(s) * 32'h1000 + 32'h0fff;
        end
        pend   = 1'b0;
        cycles = 0;

        while (aresetn !== 1'b1 && cycles < rst_timeout) begin
            @(negedge aclk);
            cycles++;
        end
        if (aresetn !== 1'b1) u_checker.report_problem("reset was never released");

        fd = $fopen("dv/apb_xbar_vectors.txt", "r");
        if (fd == 0) u_checker.report_problem("cannot open dv/apb_xbar_vectors.txt");
        while (fd != 0 && !$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            n = $sscanf(line, "%s", tok);
            if (n < 1 || tok.getc(0) == "#") continue;
            if (tok == "region") begin
                n = $sscanf(line, "%s %d %d", tok, idx, en);
                @(negedge aclk);
                regions[idx].enable = en[0];
                continue;
            end
            n = $sscanf(line, "%s %d %d %d %h %h %h %d",
                        name, m, conc, wr, addr, wdata, erd, eerr);
            if (n != 8) begin
                u_checker.report_problem({"malformed vector line ", line});
                continue;
            end
            if (pend) begin
                // two masters at once
                fork
                    run_xfer(p_m, p_name, p_wr[0], p_addr, p_wdata, p_erd, p_err[0]);
                    run_xfer(m, name, wr[0], addr, wdata, erd, eerr[0]);
                join
                pend = 1'b0;
            end else if (conc != 0) begin
                p_name  = name;
                p_m     = m;
                p_wr    = wr;
                p_addr  = addr;
                p_wdata = wdata;
                p_erd   = erd;
                p_err   = eerr;
                pend    = 1'b1;
            end else begin
                run_xfer(m, name, wr[0], addr, wdata, erd, eerr[0]);
            end
        end
        if (pend) run_xfer(p_m, p_name, p_wr[0], p_addr, p_wdata, p_erd, p_err[0]);
        if (fd != 0) $fclose(fd);

        repeat (4) @(negedge aclk);
        u_checker.print_counts();
        if (u_checker.n_fail == 0 && u_checker.n_pass > 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// ==== dv/apb_xbar_checker.sv ====
`timescale 1ns/1ns

module apb_xbar_checker #(
    parameter int n_masters = 2,
    parameter int n_slaves  = 2
) (
    input  logic                             aclk,
    input  logic                             aresetn,
    input  logic [n_masters-1:0]             i_pready,
    input  logic [n_masters-1:0][31:0]       i_prdata,
    input  logic [n_masters-1:0]             i_pslverr,
    input  logic [n_slaves-1:0]              i_s_psel,
    input  logic [n_slaves-1:0]              i_s_penable,
    input  logic [n_slaves-1:0][31:0]        i_s_paddr,
    input  logic [n_slaves-1:0][2:0]         i_s_pprot,
    input  logic [n_slaves-1:0][3:0]         i_s_pstrb
);

    string       exp_name   [n_masters];
    logic [31:0] exp_rdata  [n_masters];
    logic        exp_slverr [n_masters];
    logic        exp_miss   [n_masters];
    logic [31:0] exp_addr   [n_masters];
    logic [2:0]  exp_prot   [n_masters];
    logic [3:0]  exp_strb   [n_masters];
    logic [2:0]  got_prot   [n_masters];  // as seen at the slave setup phase
    logic [3:0]  got_strb   [n_masters];
    int          setup_snap [n_masters];
    logic        armed      [n_masters];
    int          slv_setups = 0;  // setup phases seen on all slaves
    int          n_pass     = 0;
    int          n_fail     = 0;

    initial begin
        for (int m = 0; m < n_masters; m++) armed[m] = 1'b0;
    end

    task automatic expect_xfer(input int m, input string name, input logic [31:0] rdata,
                               input logic slverr, input logic miss, input logic [31:0] addr,
                               input logic [2:0] prot, input logic [3:0] strb);
        exp_name[m]   = name;
        exp_rdata[m]  = rdata;
        exp_slverr[m] = slverr;
        exp_miss[m]   = miss;
        exp_addr[m]   = addr;
        exp_prot[m]   = prot;
        exp_strb[m]   = strb;
        got_prot[m]   = 'x;
        got_strb[m]   = 'x;
        setup_snap[m] = slv_setups;
        armed[m]      = 1'b1;
    endtask

    task automatic note_timeout(input int m, input string name);
        armed[m] = 1'b0;
        $display("test %s timed out waiting for pready on master %0d", name, m);
        n_fail++;
    endtask

    task automatic report_problem(input string msg);
        $display("%s", msg);
        n_fail++;
    endtask

    task automatic print_counts();
        $display("tests passed %0d, failed %0d", n_pass, n_fail);
    endtask

    ////////////////////////////////////////////////////////////
    // completion watch, pready is sampled on the rising edge

    always @(posedge aclk) begin
        int owner;
        if (aresetn) begin
            for (int s = 0; s < n_slaves; s++) begin
                if (i_s_psel[s] && !i_s_penable[s]) begin
                    slv_setups++;
                    owner = -1;
                    for (int m = 0; m < n_masters; m++) begin
                        if (armed[m] && exp_addr[m] == i_s_paddr[s]) owner = m;
                    end
                    if (owner < 0) begin
                        report_problem($sformatf("slave %0d saw address %h of no open transfer",
                                                 s, i_s_paddr[s]));
                    end else begin
                        got_prot[owner] = i_s_pprot[s];
                        got_strb[owner] = i_s_pstrb[s];
                    end
                end
            end
            for (int m = 0; m < n_masters; m++) begin
                if (i_pready[m] && !armed[m]) begin
                    report_problem($sformatf("master %0d gave pready with no transfer open", m));
                end else if (i_pready[m]) begin
                    armed[m] = 1'b0;
                    if (i_prdata[m] !== exp_rdata[m] || i_pslverr[m] !== exp_slverr[m]) begin
                        $display("FAILED %s expected rdata %h slverr %b actual rdata %h slverr %b",
                                 exp_name[m], exp_rdata[m], exp_slverr[m],
                                 i_prdata[m], i_pslverr[m]);
                        n_fail++;
                    end else if (!exp_miss[m] && (got_prot[m] !== exp_prot[m]
                                                  || got_strb[m] !== exp_strb[m])) begin
                        $display("FAILED %s expected pprot %h pstrb %h actual pprot %h pstrb %h",
                                 exp_name[m], exp_prot[m], exp_strb[m],
                                 got_prot[m], got_strb[m]);
                        n_fail++;
                    end else if (exp_miss[m] && slv_setups != setup_snap[m]) begin
                        report_problem({"test ", exp_name[m],
                                        " reached a slave although its address is unmapped"});
                    end else begin
                        $display("passed %s", exp_name[m]);
                        n_pass++;
                    end
                end
            end
        end
    end

endmodule

// ==== dv/apb_xbar_slave_model.sv ====
`timescale 1ns/1ns

module apb_xbar_slave_model #(
    parameter logic [31:0] base_addr = 32'h0,
    parameter logic [15:0] seed      = 16'd7156
) (
    input  logic        aclk,
    input  logic        aresetn,
    input  logic        i_psel,
    input  logic        i_penable,
    input  logic        i_pwrite,
    input  logic [31:0] i_paddr,
    input  logic [31:0] i_pwdata,
    output logic        o_pready,
    output logic [31:0] o_prdata,
    output logic        o_pslverr
);

    logic [31:0] mem [0:1023];  // 4 KiB window
    logic [15:0] lfsr;
    logic [15:0] lfsr_a;
    logic [15:0] lfsr_b;
    logic [1:0]  wait_cnt;
    logic        err;

    // fibonacci, taps 16 14 13 11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    initial begin
        for (int i = 0; i < 1024; i++) begin
            mem[i] = ~(base_addr + 32'(i) * 4);  // unwritten words read back as ~addr
        end
    end

    assign err       = (i_paddr[7:0] == 8'hEE);
    assign o_pready  = i_psel && i_penable && (wait_cnt == 2'd0);
    assign o_pslverr = o_pready && err;
    assign o_prdata  = (o_pready && !err && !i_pwrite) ? mem[i_paddr[11:2]] : '0;

    always @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            lfsr     <= seed;
            wait_cnt <= 2'd0;
        end else if (i_psel && !i_penable) begin
            // setup phase, draw 0..3 wait states, one step per bit
            lfsr_a = lfsr_step(lfsr);
            lfsr_b = lfsr_step(lfsr_a);
            wait_cnt <= {lfsr_a[0], lfsr_b[0]};
            lfsr     <= lfsr_b;
        end else if (i_psel && i_penable) begin
            if (wait_cnt != 2'd0) begin
                wait_cnt <= wait_cnt - 2'd1;
            end else if (i_pwrite && !err) begin
                mem[i_paddr[11:2]] <= i_pwdata;
            end
        end
    end

endmodule

// ==== dv/apb_xbar_clkgen.sv ====
`timescale 1ns/1ns

module apb_xbar_clkgen #(
    parameter int period_ns    = 8,
    parameter int reset_cycles = 2
) (
    output logic o_aclk,
    output logic o_aresetn
);

    initial begin
        o_aclk = 1'b0;
        forever #(period_ns / 2) o_aclk = ~o_aclk;
    end

    initial begin
        o_aresetn = 1'b0;
        repeat (reset_cycles) @(posedge o_aclk);
        @(negedge o_aclk);
        o_aresetn = 1'b1;  // release away from the sampling edge
    end

endmodule

// ==== hw/apb_xbar.sv ====
`timescale 1ns/1ns

module apb_xbar #(
    parameter int n_masters = 2,
    parameter int n_slaves  = 2
) (
    input  logic                                                 aclk,
    input  logic                                                 aresetn,
    input  apb_xbar_pkg::addr_region_t [n_slaves-1:0]            i_regions,

    // master side, APB completers
    input  logic [n_masters-1:0]                                 i_m_psel,
    input  logic [n_masters-1:0]                                 i_m_penable,
    input  logic [n_masters-1:0]                                 i_m_pwrite,
    input  logic [n_masters-1:0][2:0]                            i_m_pprot,
    input  logic [n_masters-1:0][apb_xbar_pkg::addr_w-1:0]       i_m_paddr,
    input  logic [n_masters-1:0][apb_xbar_pkg::data_w-1:0]       i_m_pwdata,
    input  logic [n_masters-1:0][apb_xbar_pkg::strb_w-1:0]       i_m_pstrb,
    output logic [n_masters-1:0]                                 o_m_pready,
    output logic [n_masters-1:0][apb_xbar_pkg::data_w-1:0]       o_m_prdata,
    output logic [n_masters-1:0]                                 o_m_pslverr,

    // slave side, APB requesters
    output logic [n_slaves-1:0]                                  o_s_psel,
    output logic [n_slaves-1:0]                                  o_s_penable,
    output logic [n_slaves-1:0]                                  o_s_pwrite,
    output logic [n_slaves-1:0][2:0]                             o_s_pprot,
    output logic [n_slaves-1:0][apb_xbar_pkg::addr_w-1:0]        o_s_paddr,
    output logic [n_slaves-1:0][apb_xbar_pkg::data_w-1:0]        o_s_pwdata,
    output logic [n_slaves-1:0][apb_xbar_pkg::strb_w-1:0]        o_s_pstrb,
    input  logic [n_slaves-1:0]                                  i_s_pready,
    input  logic [n_slaves-1:0][apb_xbar_pkg::data_w-1:0]        i_s_prdata,
    input  logic [n_slaves-1:0]                                  i_s_pslverr
);

    logic [n_masters-1:0]                   m_req_valid;
    apb_xbar_pkg::apb_req_t [n_masters-1:0] m_req;
    logic [n_masters-1:0][n_slaves-1:0]     m_slave_sel;
    logic [n_masters-1:0]                   m_done;
    apb_xbar_pkg::apb_rsp_t [n_masters-1:0] m_rsp;

    logic [n_slaves-1:0]                    s_req_valid;
    apb_xbar_pkg::apb_req_t [n_slaves-1:0]  s_req;
    logic [n_slaves-1:0]                    s_done;
    apb_xbar_pkg::apb_rsp_t [n_slaves-1:0]  s_rsp;

    ////////////////////////////////////////////////////////////
    // input side

    for (genvar m = 0; m < n_masters; m++) begin : g_mst
        apb_master_port #(
            .n_slaves   (n_slaves)
        ) u_mst_port (
            .aclk        (aclk),
            .aresetn     (aresetn),
            .i_psel      (i_m_psel[m]),
            .i_penable   (i_m_penable[m]),
            .i_pwrite    (i_m_pwrite[m]),
            .i_pprot     (i_m_pprot[m]),
            .i_paddr     (i_m_paddr[m]),
            .i_pwdata    (i_m_pwdata[m]),
            .i_pstrb     (i_m_pstrb[m]),
            .i_regions   (i_regions),
            .i_done      (m_done[m]),
            .i_rsp       (m_rsp[m]),
            .o_pready    (o_m_pready[m]),
            .o_prdata    (o_m_prdata[m]),
            .o_pslverr   (o_m_pslverr[m]),
            .o_req_valid (m_req_valid[m]),
            .o_req       (m_req[m]),
            .o_slave_sel (m_slave_sel[m])
        );
    end

    apb_xbar_switch #(
        .n_masters       (n_masters),
        .n_slaves        (n_slaves)
    ) u_switch (
        .aclk            (aclk),
        .aresetn         (aresetn),
        .i_req_valid     (m_req_valid),
        .i_req           (m_req),
        .i_slave_sel     (m_slave_sel),
        .i_slv_done      (s_done),
        .i_slv_rsp       (s_rsp),
        .o_done          (m_done),
        .o_rsp           (m_rsp),
        .o_slv_req_valid (s_req_valid),
        .o_slv_req       (s_req)
    );

    ////////////////////////////////////////////////////////////
    // output side

    for (genvar s = 0; s < n_slaves; s++) begin : g_slv
        apb_slave_port u_slv_port (
            .aclk        (aclk),
            .aresetn     (aresetn),
            .i_req_valid (s_req_valid[s]),
            .i_req       (s_req[s]),
            .i_pready    (i_s_pready[s]),
            .i_prdata    (i_s_prdata[s]),
            .i_pslverr   (i_s_pslverr[s]),
            .o_done      (s_done[s]),
            .o_rsp       (s_rsp[s]),
            .o_psel      (o_s_psel[s]),
            .o_penable   (o_s_penable[s]),
            .o_pwrite    (o_s_pwrite[s]),
            .o_pprot     (o_s_pprot[s]),
            .o_paddr     (o_s_paddr[s]),
            .o_pwdata    (o_s_pwdata[s]),
            .o_pstrb     (o_s_pstrb[s])
        );
    end

endmodule

// ==== hw/apb_slave_port.sv ====
`timescale 1ns/1ns

module apb_slave_port (
    input  logic                            aclk,
    input  logic                            aresetn,
    input  logic                            i_req_valid,
    input  apb_xbar_pkg::apb_req_t          i_req,
    input  logic                            i_pready,
    input  logic [apb_xbar_pkg::data_w-1:0] i_prdata,
    input  logic                            i_pslverr,
    output logic                            o_done,
    output apb_xbar_pkg::apb_rsp_t          o_rsp,
    output logic                            o_psel,
    output logic                            o_penable,
    output logic                            o_pwrite,
    output logic [2:0]                      o_pprot,
    output logic [apb_xbar_pkg::addr_w-1:0] o_paddr,
    output logic [apb_xbar_pkg::data_w-1:0] o_pwdata,
    output logic [apb_xbar_pkg::strb_w-1:0] o_pstrb
);

    apb_xbar_pkg::slv_state_e state;
    apb_xbar_pkg::apb_req_t   req_q;
    logic                     start;

    // the grant is still up during the done cycle, so skip it
    assign start = i_req_valid && !o_done && (state == apb_xbar_pkg::slv_idle);

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            state  <= apb_xbar_pkg::slv_idle;
            o_done <= 1'b0;
        end else begin
            o_done <= 1'b0;
            case (state)
                apb_xbar_pkg::slv_idle:  if (start) state <= apb_xbar_pkg::slv_setup;
                apb_xbar_pkg::slv_setup: state <= apb_xbar_pkg::slv_access;
                apb_xbar_pkg::slv_access: begin
                    if (i_pready) begin
                        o_done <= 1'b1;
                        state  <= apb_xbar_pkg::slv_idle;
                    end
                end
                default: state <= apb_xbar_pkg::slv_idle;
            endcase
        end
    end

    always_ff @(posedge aclk) begin
        if (start) req_q <= i_req;
        if (i_pready && (state == apb_xbar_pkg::slv_access)) begin
            o_rsp.rdata  <= i_prdata;
            o_rsp.slverr <= i_pslverr;
        end
    end

    ////////////////////////////////////////////////////////////
    // APB requester outputs

    assign o_psel    = (state != apb_xbar_pkg::slv_idle);
    assign o_penable = (state == apb_xbar_pkg::slv_access);
    assign o_pwrite  = req_q.write;
    assign o_pprot   = req_q.prot;
    assign o_paddr   = req_q.addr;
    assign o_pwdata  = req_q.wdata;
    assign o_pstrb   = req_q.strb;

    // access phase only inside a live grant
    a_penable_psel: assert property (@(posedge aclk) disable iff (!aresetn)
        o_penable |-> o_psel && i_req_valid);

    // granted request holds still until done
    a_req_stable: assert property (@(posedge aclk) disable iff (!aresetn)
        i_req_valid && !o_done |=> i_req_valid && $stable(i_req));

endmodule

// ==== hw/apb_xbar_switch.sv ====
`timescale 1ns/1ns

module apb_xbar_switch #(
    parameter int n_masters = 2,
    parameter int n_slaves  = 2
) (
    input  logic                                        aclk,
    input  logic                                        aresetn,
    input  logic [n_masters-1:0]                        i_req_valid,
    input  apb_xbar_pkg::apb_req_t [n_masters-1:0]      i_req,
    input  logic [n_masters-1:0][n_slaves-1:0]          i_slave_sel,
    input  logic [n_slaves-1:0]                         i_slv_done,
    input  apb_xbar_pkg::apb_rsp_t [n_slaves-1:0]       i_slv_rsp,
    output logic [n_masters-1:0]                        o_done,
    output apb_xbar_pkg::apb_rsp_t [n_masters-1:0]      o_rsp,
    output logic [n_slaves-1:0]                         o_slv_req_valid,
    output apb_xbar_pkg::apb_req_t [n_slaves-1:0]       o_slv_req
);

    localparam int mid_w = (n_masters > 1) ? $clog2(n_masters) : 1;

    logic [n_slaves-1:0]            slv_busy;
    logic [n_slaves-1:0][mid_w-1:0] slv_owner;
    logic                           dup_owner;

    ////////////////////////////////////////////////////////////
    // per slave arbitration

    for (genvar s = 0; s < n_slaves; s++) begin : g_slv
        logic [n_masters-1:0] reqs;
        logic [mid_w-1:0]     rr_ptr;  // first master to look at
        logic [mid_w-1:0]     pick;
        logic                 found;
        logic                 busy;
        logic [mid_w-1:0]     owner;

        always_comb begin
            for (int m = 0; m < n_masters; m++) begin
                reqs[m] = i_req_valid[m] && i_slave_sel[m][s];
            end
        end

        always_comb begin
            int idx;
            pick  = '0;
            found = 1'b0;
            for (int i = 0; i < n_masters; i++) begin
                idx = (int'(rr_ptr) + i) % n_masters;
                if (!found && reqs[idx]) begin
                    pick  = mid_w'(idx);
                    found = 1'b1;
                end
            end
        end

        // grant held until the slave port reports done
        always_ff @(posedge aclk or negedge aresetn) begin
            if (!aresetn) begin
                busy   <= 1'b0;
                owner  <= '0;
                rr_ptr <= '0;
            end else if (busy) begin
                if (i_slv_done[s]) begin
                    busy   <= 1'b0;
                    rr_ptr <= (int'(owner) == n_masters - 1) ? '0 : owner + 1'b1;
                end
            end else if (found) begin
                busy  <= 1'b1;
                owner <= pick;
            end
        end

        assign slv_busy[s]        = busy;
        assign slv_owner[s]       = owner;
        assign o_slv_req_valid[s] = busy;
        assign o_slv_req[s]       = i_req[owner];
    end

    ////////////////////////////////////////////////////////////
    // response return

    always_comb begin
        o_done = '0;
        o_rsp  = '0;
        for (int s = 0; s < n_slaves; s++) begin
            if (slv_busy[s] && i_slv_done[s]) begin
                o_done[slv_owner[s]] = 1'b1;
                o_rsp[slv_owner[s]]  = i_slv_rsp[s];
            end
        end
    end

    always_comb begin
        dup_owner = 1'b0;
        for (int a = 0; a < n_slaves; a++) begin
            for (int b = a + 1; b < n_slaves; b++) begin
                if (slv_busy[a] && slv_busy[b] && (slv_owner[a] == slv_owner[b])) begin
                    dup_owner = 1'b1;
                end
            end
        end
    end

    // a master has one transfer in flight, so only one slave may own it
    a_single_owner: assert property (@(posedge aclk) disable iff (!aresetn) !dup_owner);

endmodule

// ==== hw/apb_master_port.sv ====
`timescale 1ns/1ns

module apb_master_port #(
    parameter int n_slaves = 2
) (
    input  logic                                      aclk,
    input  logic                                      aresetn,
    input  logic                                      i_psel,
    input  logic                                      i_penable,
    input  logic                                      i_pwrite,
    input  logic [2:0]                                i_pprot,
    input  logic [apb_xbar_pkg::addr_w-1:0]           i_paddr,
    input  logic [apb_xbar_pkg::data_w-1:0]           i_pwdata,
    input  logic [apb_xbar_pkg::strb_w-1:0]           i_pstrb,
    input  apb_xbar_pkg::addr_region_t [n_slaves-1:0] i_regions,
    input  logic                                      i_done,
    input  apb_xbar_pkg::apb_rsp_t                    i_rsp,
    output logic                                      o_pready,
    output logic [apb_xbar_pkg::data_w-1:0]           o_prdata,
    output logic                                      o_pslverr,
    output logic                                      o_req_valid,
    output apb_xbar_pkg::apb_req_t                    o_req,
    output logic [n_slaves-1:0]                       o_slave_sel
);

    apb_xbar_pkg::mst_state_e state;
    apb_xbar_pkg::apb_rsp_t   rsp_q;
    logic [n_slaves-1:0]      hit_sel;
    logic                     hit;
    logic                     start;

    assign start = i_psel && i_penable && (state == apb_xbar_pkg::mst_idle);

    // lowest matching region wins
    always_comb begin
        hit_sel = '0;
        hit     = 1'b0;
        for (int s = 0; s < n_slaves; s++) begin
            if (!hit && i_regions[s].enable && (i_paddr >= i_regions[s].base)
                    && (i_paddr <= i_regions[s].limit)) begin
                hit_sel[s] = 1'b1;
                hit        = 1'b1;
            end
        end
    end

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            state       <= apb_xbar_pkg::mst_idle;
            o_req_valid <= 1'b0;
            o_slave_sel <= '0;
        end else begin
            case (state)
                apb_xbar_pkg::mst_idle: begin
                    if (start && hit) begin
                        o_req_valid <= 1'b1;
                        o_slave_sel <= hit_sel;
                        state       <= apb_xbar_pkg::mst_wait_resp;
                    end else if (start) begin
                        state <= apb_xbar_pkg::mst_respond;  // miss, answer locally
                    end
                end
                apb_xbar_pkg::mst_wait_resp: begin
                    if (i_done) begin
                        o_req_valid <= 1'b0;
                        state       <= apb_xbar_pkg::mst_respond;
                    end
                end
                default: state <= apb_xbar_pkg::mst_idle;
            endcase
        end
    end

    always_ff @(posedge aclk) begin
        if (start) begin
            o_req.write  <= i_pwrite;
            o_req.prot   <= i_pprot;
            o_req.addr   <= i_paddr;
            o_req.wdata  <= i_pwdata;
            o_req.strb   <= i_pstrb;
            rsp_q.rdata  <= '0;
            rsp_q.slverr <= !hit;  // replaced on a hit
        end else if (i_done && (state == apb_xbar_pkg::mst_wait_resp)) begin
            rsp_q <= i_rsp;
        end
    end

    assign o_pready  = (state == apb_xbar_pkg::mst_respond);
    assign o_prdata  = rsp_q.rdata;
    assign o_pslverr = rsp_q.slverr;

    a_sel_onehot0: assert property (@(posedge aclk) disable iff (!aresetn)
        $onehot0(o_slave_sel));

    // the switch only answers a transfer that is waiting for it
    a_done_owned: assert property (@(posedge aclk) disable iff (!aresetn)
        i_done |-> o_req_valid && (state == apb_xbar_pkg::mst_wait_resp));

endmodule

// ==== hw/apb_xbar_pkg.sv ====
package apb_xbar_pkg;

    ////////////////////////////////////////////////////////////
    // bus widths

    localparam int addr_w = 32;
    localparam int data_w = 32;
    localparam int strb_w = data_w / 8;

    ////////////////////////////////////////////////////////////
    // transfer payloads

    // one APB transfer as seen by the switch
    typedef struct packed {
        logic              write;
        logic [2:0]        prot;  // passed through untouched
        logic [addr_w-1:0] addr;
        logic [data_w-1:0] wdata;
        logic [strb_w-1:0] strb;
    } apb_req_t;

    typedef struct packed {
        logic [data_w-1:0] rdata;
        logic              slverr;
    } apb_rsp_t;

    // decode window per slave, limit is inclusive
    typedef struct packed {
        logic              enable;
        logic [addr_w-1:0] base;
        logic [addr_w-1:0] limit;
    } addr_region_t;

    ////////////////////////////////////////////////////////////
    // FSM states

    typedef enum logic [1:0] {
        mst_idle,
        mst_wait_resp,  // request is with the switch
        mst_respond     // pready cycle
    } mst_state_e;

    typedef enum logic [1:0] {
        slv_idle,
        slv_setup,
        slv_access
    } slv_state_e;

endpackage
